// ==== sources.f ====
+incdir+src
src/apbIcPkg.sv
src/apbSlotDecoder.sv
src/apbIndirectAddr.sv
src/apbResponseMux.sv
src/apbInterconnect.sv
dv/tbClockGen.sv
dv/tbApbInterconnect.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build with Verilator, run, and judge the result from the log
cd "$(dirname "$0")" || exit 1

rm -f sim.log

verilator --binary --timing --assert -f sources.f \
  --top-module tbApbInterconnect -o simApb \
  && ./obj_dir/simApb | tee sim.log \
  || { echo "Build or simulation run failed"; exit 1; }

grep -q "All tests passed!" sim.log && exit 0 || exit 1

// ==== dv/tbApbInterconnect.sv ====
// APB interconnect testbench
`timescale 1ns/1ps
`include "apbIcCfg.svh"

module tbApbInterconnect
  import apbIcPkg::*;
;

  localparam int       NumTests   = 5;
  localparam slotSel_t EnableMask = `APB_SLOT_ENABLE;

  logic         pclk;
  logic         rstN;
  logic         psel;
  apbReq_t      req;
  apbRsp_t      rsp;
  apbReq_t      slaveReq;
  slotSel_t     pselS;
  apbRspArray_t slotRsp;
  slotSel_t     readyLvl;

  // Captured at the access cycle where the master sees ready
  apbRsp_t      lastRsp;
  slotSel_t     lastSel;
  apbReq_t      lastFwd;
  int           stallCycles;

  int           errCount;
  int           checkCount;
  int           testCount;
  int           testErrs;
  string        curTest;

  tbClockGen #(.PeriodNs(8), .ResetCycles(10)) iClk (.clk(pclk), .rstN(rstN));

  apbInterconnect i_dut (
    .pclk     (pclk),
    .rstN     (rstN),
    .psel     (psel),
    .req      (req),
    .rsp      (rsp),
    .slaveReq (slaveReq),
    .pselS    (pselS),
    .slotRsp  (slotRsp)
  );

  // Slot index in the top byte XOR the low address half
  function automatic logic [31:0] slotData(input int idx, input logic [31:0] addr);
    slotData = {8'(idx), 24'h0} ^ {16'h0, addr[15:0]};
  endfunction

  function automatic logic [31:0] randAddr(input int slot);
    logic [31:0] r;
    r = $urandom;
    randAddr = {r[31:16], 4'(slot), r[11:0]};
  endfunction

  // Slot models where odd slots flag an error
  always_comb
  begin
    for (int i = 0; i < `APB_NUM_SLOTS; i++)
    begin
      slotRsp[i].rdata  = slotData(i, slaveReq.addr);
      slotRsp[i].ready  = readyLvl[i];
      slotRsp[i].slvErr = 1'(i % 2);
    end
  end

  task automatic checkEq(input string what, input logic [31:0] exp, input logic [31:0] act);
    checkCount++;
    if (exp !== act)
    begin
      $display("** Error %s: %s expected %h actual %h", curTest, what, exp, act);
      errCount++;
      testErrs++;
    end
  endtask

  task automatic startTest(input string name);
    curTest  = name;
    testErrs = 0;
    testCount++;
  endtask

  task automatic endTest();
    $display("%s finished with %0d errors", curTest, testErrs);
  endtask

  // One setup cycle and then access cycles until ready
  task automatic runAccess(input logic [31:0] addr, input logic write,
                           input logic [31:0] wdata, input int waitCycles);
    int  s;
    int  k;
    logic done;
    s = int'(addr[15:12]);
    k = 0;
    done = 1'b0;
    stallCycles = 0;
    @(posedge pclk);
    #1;
    psel = 1'b1;
    req.addr = addr;
    req.write = write;
    req.wdata = wdata;
    req.enable = 1'b0;
    readyLvl = '1;
    if (waitCycles > 0)
      readyLvl[s] = 1'b0;
    while (!done)
    begin
      @(posedge pclk);
      #1;
      req.enable = 1'b1;
      if (k >= waitCycles)
        readyLvl[s] = 1'b1;
      @(negedge pclk);
      if (rsp.ready)
      begin
        done = 1'b1;
        lastRsp = rsp;
        lastSel = pselS;
        lastFwd = slaveReq;
      end
      else
        stallCycles++;
      k++;
    end
    @(posedge pclk);
    #1;
    psel = 1'b0;
    req.enable = 1'b0;
    readyLvl = '1;
  endtask

  task automatic testDecodeForward();
    logic [31:0] addr;
    logic [31:0] wdata;
    logic        wr;
    startTest("decode_forward");
    for (int s = 0; s < `APB_NUM_SLOTS; s++)
    begin
      if (EnableMask[s] && s != `APB_IADDR_SLOT)
      begin
        addr = randAddr(s);
        wdata = $urandom;
        wr = 1'($urandom % 2);
        runAccess(addr, wr, wdata, 0);
        checkEq("select", 32'(1) << s, 32'(lastSel));
        checkEq("write", 32'(wr), 32'(lastFwd.write));
        checkEq("enable", 32'd1, 32'(lastFwd.enable));
        checkEq("wdata", wdata, lastFwd.wdata);
        checkEq("addr low", 32'(addr[15:0]), 32'(lastFwd.addr[15:0]));
      end
    end
    endTest();
  endtask

  task automatic testReadReturn();
    logic [31:0] addr;
    startTest("read_return");
    for (int s = 0; s < `APB_NUM_SLOTS; s++)
    begin
      if (EnableMask[s] && s != `APB_IADDR_SLOT)
      begin
        addr = randAddr(s);
        runAccess(addr, 1'b0, 32'h0, 0);
        checkEq("rdata", slotData(s, addr), lastRsp.rdata);
        checkEq("slvErr", 32'(s % 2), 32'(lastRsp.slvErr));
      end
    end
    endTest();
  endtask

  task automatic testWaitStates();
    logic [31:0] addr;
    int          s;
    int          w;
    startTest("wait_states");
    for (int n = 0; n < 6; n++)
    begin
      s = int'($urandom % 14);
      w = 1 + int'($urandom % 5);
      addr = randAddr(s);
      runAccess(addr, 1'b0, 32'h0, w);
      checkEq("stall cycles", w, stallCycles);
      checkEq("rdata", slotData(s, addr), lastRsp.rdata);
    end
    endTest();
  endtask

  task automatic testDisabledSlot();
    startTest("disabled_slot");
    runAccess(randAddr(14), 1'b0, 32'h0, 3);
    checkEq("select", 32'h0, 32'(lastSel));
    checkEq("stall cycles", 0, stallCycles);
    checkEq("rdata", 32'h0, lastRsp.rdata);
    checkEq("slvErr", 32'h0, 32'(lastRsp.slvErr));
    endTest();
  endtask

  task automatic testIndirect();
    logic [31:0] addr;
    logic [31:0] val;
    startTest("indirect_reg");
    runAccess(randAddr(3), 1'b0, 32'h0, 0);
    checkEq("upper after reset", 32'h0, 32'(lastFwd.addr[31:16]));
    val = $urandom;
    runAccess(randAddr(`APB_IADDR_SLOT), 1'b1, val, 0);
    checkEq("write select", 32'h0, 32'(lastSel));
    runAccess(randAddr(`APB_IADDR_SLOT), 1'b0, 32'h0, 0);
    checkEq("read select", 32'h0, 32'(lastSel));
    checkEq("readback", val, lastRsp.rdata);
    checkEq("slvErr", 32'h0, 32'(lastRsp.slvErr));
    addr = randAddr(5);
    runAccess(addr, 1'b0, 32'h0, 0);
    checkEq("slot addr", {val[31:16], addr[15:0]}, lastFwd.addr);
    endTest();
  endtask

  initial
  begin
    void'($urandom(10445));
    psel = 1'b0;
    req = '0;
    readyLvl = '1;
    errCount = 0;
    checkCount = 0;
    testCount = 0;
    wait (rstN === 1'b1);
    testDecodeForward();
    testReadReturn();
    testWaitStates();
    testDisabledSlot();
    testIndirect();
    $display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errCount);
    if (errCount == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

  initial
  begin
    repeat (NumTests * 200) @(posedge pclk);
    $display("Watchdog expired after %0d cycles, a transfer never completed", NumTests * 200);
    $display("Test failures found");
    $finish;
  end

endmodule

// ==== dv/tbClockGen.sv ====
// Testbench clock and reset
`timescale 1ns/1ps

module tbClockGen #(
  parameter int PeriodNs    = 8,
  parameter int ResetCycles = 10
) (
  output logic clk,
  output logic rstN
);

  initial
  begin
    clk = 1'b0;
    forever #(PeriodNs / 2) clk = ~clk;
  end

  // Release reset just after an edge so it never races the clock
  initial
  begin
    rstN = 1'b0;
    repeat (ResetCycles) @(posedge clk);
    #1;
    rstN = 1'b1;
  end

endmodule

// ==== src/apbInterconnect.sv ====
// APB3 interconnect top
`timescale 1ns/1ps
`include "apbIcCfg.svh"

module apbInterconnect
  import apbIcPkg::*;
(
  input  logic         pclk,
  input  logic         rstN,

  // Master side
  input  logic         psel,
  input  apbReq_t      req,
  output apbRsp_t      rsp,

  // Slot side
  output apbReq_t      slaveReq,
  output slotSel_t     pselS,
  input  apbRspArray_t slotRsp
);

  localparam int       LowW      = `APB_SLOT_MSB + 1;
  localparam slotSel_t IaddrMask = slotSel_t'(1) << `APB_IADDR_SLOT;

  slotSel_t slotSel;
  apbRsp_t  iaddrRsp;
  slotSel_t slotReady;

  apbSlotDecoder iDecoder (
    .psel    (psel),
    .addr    (req.addr),
    .slotSel (slotSel)
  );

  apbIndirectAddr iIndirect (
    .pclk     (pclk),
    .rstN     (rstN),
    .sel      (slotSel[`APB_IADDR_SLOT]),
    .req      (req),
    .slaveReq (slaveReq),
    .rsp      (iaddrRsp)
  );

  apbResponseMux iMux (
    .slotSel  (slotSel),
    .slotRsp  (slotRsp),
    .iaddrRsp (iaddrRsp),
    .rsp      (rsp)
  );

  // Register slot lives on chip, nothing outside sees its select
  assign pselS = slotSel & ~IaddrMask;

  always_comb
  begin
    for (int i = 0; i < `APB_NUM_SLOTS; i++)
    begin
      slotReady[i] = slotRsp[i].ready;
    end
  end

  // Wait states of an external slot pass straight through
  apReadyPass: assert property (
    @(posedge pclk) disable iff (!rstN)
    (|pselS) |-> rsp.ready == |(pselS & slotReady)
  )
  else
    $error("master ready differs from selected slot ready");

  // Master writes to the register slot land in the slot address next cycle
  apIaddrPath: assert property (
    @(posedge pclk) disable iff (!rstN)
    (psel && req.addr[`APB_SLOT_MSB:`APB_SLOT_LSB] == `APB_IADDR_SLOT
      && req.enable && req.write)
    |=> slaveReq.addr[`APB_ADDR_W-1:LowW] == $past(req.wdata[`APB_ADDR_W-1:LowW])
  )
  else
    $error("indirect write did not reach slot address");

  // External selects never fire while the master is idle
  apIdleQuiet: assert property (
    @(posedge pclk) disable iff (!rstN)
    !psel |-> pselS == '0 && rsp.ready
  )
  else
    $error("slot select or stall while master idle");

endmodule

// ==== src/apbResponseMux.sv ====
// APB slot response multiplexer
`timescale 1ns/1ps
`include "apbIcCfg.svh"

module apbResponseMux
  import apbIcPkg::*;
(
  input  slotSel_t     slotSel,
  input  apbRspArray_t slotRsp,
  input  apbRsp_t      iaddrRsp,
  output apbRsp_t      rsp
);

  localparam slotSel_t EnableMask = `APB_SLOT_ENABLE;

  // Completion for accesses that hit no live slot
  localparam apbRsp_t IdleRsp = '{rdata: '0, ready: 1'b1, slvErr: 1'b0};

  apbRspArray_t srcRsp;
  slotSel_t     readyVec;
  slotSel_t     errVec;
  logic         anySel;
  logic [`APB_DATA_W-1:0] dataOr;

  // Indirect slot answers from the register, not from the slot port
  always_comb
  begin
    for (int i = 0; i < `APB_NUM_SLOTS; i++)
    begin
      if (i == `APB_IADDR_SLOT)
      begin
        srcRsp[i] = iaddrRsp;
      end
      else
      begin
        srcRsp[i] = slotRsp[i];
      end
    end
  end

  // AND-OR select, slotSel is one-hot
  always_comb
  begin
    dataOr = '0;
    for (int i = 0; i < `APB_NUM_SLOTS; i++)
    begin
      if (slotSel[i])
      begin
        dataOr = dataOr | srcRsp[i].rdata;
      end
      readyVec[i] = srcRsp[i].ready;
      errVec[i]   = srcRsp[i].slvErr;
    end
  end

  assign anySel = |slotSel;

  always_comb
  begin
    if (anySel)
    begin
      rsp.rdata  = dataOr;
      rsp.ready  = |(slotSel & readyVec);
      rsp.slvErr = |(slotSel & errVec);
    end
    else
    begin
      rsp = IdleRsp;
    end
  end

  // Decoder must keep empty slots out of the select
  always_comb
  begin
    assert ((slotSel & ~EnableMask) == '0)
    else
      $error("disabled slot selected: %b", slotSel);
  end

endmodule

// ==== src/apbIndirectAddr.sv ====
// APB indirect address register
`timescale 1ns/1ps
`include "apbIcCfg.svh"

module apbIndirectAddr
  import apbIcPkg::*;
(
  input  logic    pclk,
  input  logic    rstN,
  input  logic    sel,
  input  apbReq_t req,
  output apbReq_t slaveReq,
  output apbRsp_t rsp
);

  // Master keeps the address bits up to and including the slot field
  localparam int LowW = `APB_SLOT_MSB + 1;

  logic [`APB_DATA_W-1:0] iaddrReg;
  logic                   wrEn;
  logic [`APB_ADDR_W-1:0] slaveAddr;

  // Register answers with ready high, so the access phase is one cycle
  assign wrEn = sel & req.enable & req.write;

  always_ff @(posedge pclk or negedge rstN)
  begin
    if (!rstN)
    begin
      iaddrReg <= '0;
    end
    else if (wrEn)
    begin
      iaddrReg <= req.wdata;
    end
  end

  // Read back never stalls and never errors
  always_comb
  begin
    rsp.rdata  = iaddrReg;
    rsp.ready  = 1'b1;
    rsp.slvErr = 1'b0;
  end

  // Upper half from the register, lower half from the master
  assign slaveAddr = {iaddrReg[`APB_ADDR_W-1:LowW], req.addr[LowW-1:0]};

  always_comb
  begin
    slaveReq        = req;
    slaveReq.addr   = slaveAddr;
  end

  // Register only moves after a write to its own slot
  apIaddrHold: assert property (
    @(posedge pclk) disable iff (!rstN)
    $changed(iaddrReg) |-> $past(wrEn)
  )
  else
    $error("indirect register changed without a selected write");

endmodule

// ==== src/apbSlotDecoder.sv ====
// APB slot address decoder
`timescale 1ns/1ps
`include "apbIcCfg.svh"

module apbSlotDecoder
  import apbIcPkg::*;
(
  input  logic                   psel,
  input  logic [`APB_ADDR_W-1:0] addr,
  output slotSel_t               slotSel
);

  localparam slotSel_t EnableMask = `APB_SLOT_ENABLE;

  slotIdx_t slotIdx;
  slotSel_t slotHit;
  slotSel_t slotLive;

  assign slotIdx = addr[`APB_SLOT_MSB:`APB_SLOT_LSB];

  // Full one-hot decode of the slot field
  always_comb
  begin
    slotHit = '0;
    for (int i = 0; i < `APB_NUM_SLOTS; i++)
    begin
      if (slotIdx == slotIdx_t'(i))
      begin
        slotHit[i] = 1'b1;
      end
    end
  end

  // Empty slots drop out here, so the mux falls back to its idle response
  assign slotLive = slotHit & EnableMask;

  always_comb
  begin
    if (psel)
    begin
      slotSel = slotLive;
    end
    else
    begin
      slotSel = '0;
    end
  end

  // At most one slot is ever driven
  always_comb
  begin
    assert ($onehot0(slotSel))
    else
      $error("slot select not one-hot: %b", slotSel);
  end

endmodule

// ==== src/apbIcPkg.sv ====
// APB interconnect types
`include "apbIcCfg.svh"

package apbIcPkg;

  // Request from the master, also forwarded to the slots
  typedef struct packed {
    logic [`APB_ADDR_W-1:0] addr;
    logic                   write;
    logic                   enable;
    logic [`APB_DATA_W-1:0] wdata;
  } apbReq_t;

  // Completion seen by the master or returned by one slot
  typedef struct packed {
    logic [`APB_DATA_W-1:0] rdata;
    logic                   ready;
    logic                   slvErr;
  } apbRsp_t;

  // All slot responses, indexed by slot number
  typedef apbRsp_t [`APB_NUM_SLOTS-1:0] apbRspArray_t;

  // One-hot slot select
  typedef logic [`APB_NUM_SLOTS-1:0] slotSel_t;

  // Slot field taken out of the address
  typedef logic [`APB_SLOT_MSB-`APB_SLOT_LSB:0] slotIdx_t;

endpackage

// ==== src/apbIcCfg.svh ====
// APB interconnect configuration
`ifndef APB_IC_CFG_SVH
`define APB_IC_CFG_SVH

// Bus widths
`define APB_DATA_W 32
`define APB_ADDR_W 32

// Number of peripheral slots behind the interconnect
`define APB_NUM_SLOTS 16

// Address bits that pick the slot
`define APB_SLOT_MSB 15
`define APB_SLOT_LSB 12

// Populated slots, one bit per slot, slot 14 left empty
`define APB_SLOT_ENABLE 16'hBFFF

// Slot taken by the on-chip indirect address register
`define APB_IADDR_SLOT 15

`endif
